// File: alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
	input wire logic clk,
	input wire logic rst,
	input wire cpuPkg::opcodeT op,
	input wire logic update,
	input wire logic [cpuPkg::dataWidth-1:0] in1,
	input wire logic [cpuPkg::dataWidth-1:0] in2,
	output logic [cpuPkg::dataWidth-1:0] result,
	output logic cFlag,
	output logic zFlag
);
	import cpuPkg::*;

	// One extra bit on top carries the carry or borrow
	logic [dataWidth:0] wide;
	logic setsFlags;

	always_comb begin
		case (op)
			opAdd: wide = {1'b0, in1} + {1'b0, in2};
			opSub: wide = {1'b0, in1} - {1'b0, in2};
			opAnd: wide = {1'b0, in1 & in2};
			opOr: wide = {1'b0, in1 | in2};
			opXor: wide = {1'b0, in1 ^ in2};
			// Shifts act on the dst operand, one bit at a time
			opShl: wide = {in1, 1'b0};
			opShr: wide = {in1[0], 1'b0, in1[dataWidth-1:1]};
			// Mov and everything else pass src through
			default: wide = {1'b0, in2};
		endcase
	end

	assign result = wide[dataWidth-1:0];

	// Only the arithmetic and logic group touches the flags
	assign setsFlags = op inside {opAdd, opSub, opAnd, opOr, opXor, opShl, opShr};

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end
		else if (update && setsFlags) begin
			cFlag <= wide[dataWidth];
			zFlag <= (result == '0);
		end
	end

endmodule

`default_nettype wire

// File: cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int dataWidth = 16;

	// Opcode lives in instruction bits 15..12
	typedef enum logic [3:0] {
		opAdd,
		opSub,
		opAnd,
		opOr,
		opXor,
		opShl,
		opShr,
		opMov,
		opLdi,
		opLd,
		opSt,
		opJmp,
		opJr,
		opJz,
		opJc,
		opHalt
	} opcodeT;

	typedef enum logic [1:0] {selAlu, selMem, selImm} regDataSelT;
	typedef enum logic [1:0] {addrDst, addrSrc, addrImm} memAddrSelT;
	typedef enum logic [1:0] {pcInc, pcImm, pcReg, pcHold} nextPcSelT;

	typedef struct packed {
		opcodeT aluOp;
		logic regWe;
		logic memWe;
		regDataSelT regDataSel;
		memAddrSelT memAddrSel;
		nextPcSelT nextPcSel;
		logic halt;
	} ctrlT;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [11:0] paddr;
		logic [15:0] pwdata;
	} apbReqT;

	typedef struct packed {
		logic [15:0] prdata;
		logic pready;
		logic pslverr;
	} apbRspT;

	// APB regions decoded from paddr[11:10]
	localparam logic [1:0] regionInstr = 2'd0;
	localparam logic [1:0] regionData = 2'd1;
	localparam logic [1:0] regionCtrl = 2'd2;

endpackage

`default_nettype wire

// File: decoder.sv
`timescale 1ns/100ps
`default_nettype none

module decoder (
	input wire logic [cpuPkg::dataWidth-1:0] instruction,
	input wire logic cFlag,
	input wire logic zFlag,
	output cpuPkg::ctrlT ctrl,
	output logic [3:0] dstIdx,
	output logic [3:0] srcIdx,
	output logic [cpuPkg::dataWidth-1:0] immData
);
	import cpuPkg::*;

	opcodeT opcode;

	// Field split; imm overlaps the src field
	assign opcode = opcodeT'(instruction[15:12]);
	assign dstIdx = instruction[11:8];
	assign srcIdx = instruction[7:4];
	assign immData = {{(dataWidth-8){1'b0}}, instruction[7:0]};

	always_comb begin
		ctrl.aluOp = opcode;
		ctrl.regWe = 1'b0;
		ctrl.memWe = 1'b0;
		ctrl.regDataSel = selAlu;
		ctrl.memAddrSel = addrImm;
		ctrl.nextPcSel = pcInc;
		ctrl.halt = 1'b0;

		case (opcode)
			opAdd, opSub, opAnd, opOr, opXor, opShl, opShr, opMov: begin
				ctrl.regWe = 1'b1;
			end
			opLdi: begin
				ctrl.regWe = 1'b1;
				ctrl.regDataSel = selImm;
			end
			// dst = mem[src]
			opLd: begin
				ctrl.regWe = 1'b1;
				ctrl.regDataSel = selMem;
				ctrl.memAddrSel = addrSrc;
			end
			// mem[dst] = src
			opSt: begin
				ctrl.memWe = 1'b1;
				ctrl.memAddrSel = addrDst;
			end
			opJmp: ctrl.nextPcSel = pcImm;
			opJr: ctrl.nextPcSel = pcReg;
			opJz: ctrl.nextPcSel = zFlag ? pcImm : pcInc;
			opJc: ctrl.nextPcSel = cFlag ? pcImm : pcInc;
			opHalt: begin
				ctrl.nextPcSel = pcHold;
				ctrl.halt = 1'b1;
			end
			default: begin
				ctrl.nextPcSel = pcInc;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: memorySystem.sv
`timescale 1ns/100ps
`default_nettype none

module memorySystem #(
	parameter int memDepth = 128
) (
	input wire logic clk,
	input wire logic rst,
	input wire cpuPkg::apbReqT apbReq,
	output cpuPkg::apbRspT apbRsp,
	input wire logic [$clog2(memDepth)-1:0] pc,
	output logic [cpuPkg::dataWidth-1:0] instruction,
	input wire logic [$clog2(memDepth)-1:0] memAddr,
	input wire logic [cpuPkg::dataWidth-1:0] memWriteData,
	input wire logic memWe,
	output logic [cpuPkg::dataWidth-1:0] memReadData,
	input wire logic haltReq,
	output logic run
);
	import cpuPkg::*;

	localparam int addrWidth = $clog2(memDepth);

	logic [dataWidth-1:0] instrMem [memDepth];
	logic [dataWidth-1:0] dataMem [memDepth];

	logic access;
	logic apbWrite;
	logic memRegion;
	logic [1:0] region;
	logic [addrWidth-1:0] apbIdx;

	// Access phase of an APB transfer, pready is tied high
	assign access = apbReq.psel & apbReq.penable;
	assign apbWrite = access & apbReq.pwrite;
	assign region = apbReq.paddr[11:10];
	assign apbIdx = apbReq.paddr[addrWidth+1:2];
	assign memRegion = (region == regionInstr) || (region == regionData);

	// Run bit, cleared by a retiring halt
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			run <= 1'b0;
		end
		else if (haltReq) begin
			run <= 1'b0;
		end
		else if (apbWrite && region == regionCtrl) begin
			run <= apbReq.pwdata[0];
		end
	end

	always_ff @(posedge clk) begin
		if (apbWrite && !run && region == regionInstr) begin
			instrMem[apbIdx] <= apbReq.pwdata;
		end
	end

	// Core and host never write together, host is locked out while running
	always_ff @(posedge clk) begin
		if (memWe) begin
			dataMem[memAddr] <= memWriteData;
		end
		else if (apbWrite && !run && region == regionData) begin
			dataMem[apbIdx] <= apbReq.pwdata;
		end
	end

	assign instruction = instrMem[pc];
	assign memReadData = dataMem[memAddr];

	always_comb begin
		apbRsp = '0;
		apbRsp.pready = 1'b1;
		apbRsp.pslverr = apbWrite & run & memRegion;
		if (access && !apbReq.pwrite) begin
			case (region)
				regionInstr: apbRsp.prdata = instrMem[apbIdx];
				regionData: apbRsp.prdata = dataMem[apbIdx];
				regionCtrl: begin
					// Status word, run on top and PC at the bottom
					apbRsp.prdata[dataWidth-1] = run;
					apbRsp.prdata[addrWidth-1:0] = pc;
				end
				default: apbRsp.prdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: processor.sv
`timescale 1ns/100ps
`default_nettype none

module processor #(
	parameter int memDepth = 128
) (
	input wire logic clk,
	input wire logic rst,
	input wire cpuPkg::apbReqT apbReq,
	output cpuPkg::apbRspT apbRsp
);
	import cpuPkg::*;

	localparam int addrWidth = $clog2(memDepth);

	ctrlT ctrl;
	logic run;
	logic [addrWidth-1:0] pc;
	logic [addrWidth-1:0] nextPc;
	logic [dataWidth-1:0] instruction;
	logic [dataWidth-1:0] immData;
	logic [3:0] dstIdx;
	logic [3:0] srcIdx;
	logic [dataWidth-1:0] dstData;
	logic [dataWidth-1:0] srcData;
	logic [dataWidth-1:0] regWriteData;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] memReadData;
	logic [addrWidth-1:0] memAddr;
	logic cFlag;
	logic zFlag;

	always_comb begin
		case (ctrl.nextPcSel)
			pcImm: nextPc = immData[addrWidth-1:0];
			pcReg: nextPc = srcData[addrWidth-1:0];
			pcHold: nextPc = pc;
			default: nextPc = pc + 1'b1;
		endcase
	end

	// PC only moves while the core is running
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			pc <= '0;
		end
		else if (run) begin
			pc <= nextPc;
		end
	end

	always_comb begin
		case (ctrl.regDataSel)
			selMem: regWriteData = memReadData;
			selImm: regWriteData = immData;
			default: regWriteData = aluResult;
		endcase
	end

	always_comb begin
		case (ctrl.memAddrSel)
			addrDst: memAddr = dstData[addrWidth-1:0];
			addrSrc: memAddr = srcData[addrWidth-1:0];
			default: memAddr = immData[addrWidth-1:0];
		endcase
	end

	decoder decode (.instruction(instruction), .cFlag(cFlag), .zFlag(zFlag), .ctrl(ctrl),
		.dstIdx(dstIdx), .srcIdx(srcIdx), .immData(immData));

	regFile registers (.clk(clk), .rst(rst), .we(ctrl.regWe & run), .dstIdx(dstIdx),
		.srcIdx(srcIdx), .writeData(regWriteData), .dstData(dstData), .srcData(srcData));

	// in1 is dst, in2 is src
	alu aluUnit (.clk(clk), .rst(rst), .op(ctrl.aluOp), .update(run), .in1(dstData),
		.in2(srcData), .result(aluResult), .cFlag(cFlag), .zFlag(zFlag));

	memorySystem #(.memDepth(memDepth)) memory (.clk(clk), .rst(rst), .apbReq(apbReq),
		.apbRsp(apbRsp), .pc(pc), .instruction(instruction), .memAddr(memAddr),
		.memWriteData(srcData), .memWe(ctrl.memWe & run), .memReadData(memReadData),
		.haltReq(ctrl.halt & run), .run(run));

endmodule

`default_nettype wire

// File: processorTb.sv
`timescale 1ns/100ps
`default_nettype none

module processorTb;
	import cpuPkg::*;

	localparam int period = 40;
	localparam int resetCycles = 16;
	localparam int maxTransfers = 300;
	localparam int cycleBudget = 4;
	localparam logic [11:0] ctrlAddr = {regionCtrl, 10'h000};

	logic clk = 1'b0;
	logic rst;
	apbReqT apbReq;
	apbRspT apbRsp;
	int errorCount = 0;
	logic [15:0] prog [$];
	logic [15:0] rdata;
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] expected [8];
	logic [15:0] markers [6];
	logic [6:0] haltPc;
	logic err;
	opcodeT aluOps [8] = '{opAdd, opSub, opAnd, opOr, opXor, opShl, opShr, opMov};

	always #(period / 2) clk = ~clk;

	processor #(.memDepth(128)) dut (.clk(clk), .rst(rst), .apbReq(apbReq),
		.apbRsp(apbRsp));

	// Every access cycle completes at once
	assert property (@(posedge clk) (apbReq.psel && apbReq.penable) |-> apbRsp.pready)
	else begin
		errorCount++;
		$display("Error at %0t ns: pready low in an access cycle", $time);
	end

	function automatic logic [11:0] addrOf(input logic [1:0] region, input logic [6:0] idx);
		return {region, 1'b0, idx, 2'b00};
	endfunction

	function automatic logic [15:0] regInstr(input logic [3:0] op, input logic [3:0] d,
		input logic [3:0] s);
		return {op, d, s, 4'h0};
	endfunction

	function automatic logic [15:0] immInstr(input logic [3:0] op, input logic [3:0] d,
		input logic [7:0] imm);
		return {op, d, imm};
	endfunction

	task automatic checkValue(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got == exp) else begin
			errorCount++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Reset starts and ends on a falling edge
	task automatic applyReset();
		rst = 1'b1;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	endtask

	// Setup and access cycles followed by one idle cycle
	task automatic apbWrite(input logic [11:0] addr, input logic [15:0] data,
		output logic slvErr);
		@(negedge clk);
		apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(negedge clk);
		apbReq.penable = 1'b1;
		#(period / 4);
		slvErr = apbRsp.pslverr;
		@(negedge clk);
		apbReq = '0;
	endtask

	task automatic apbRead(input logic [11:0] addr, output logic [15:0] data);
		@(negedge clk);
		apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 16'h0};
		@(negedge clk);
		apbReq.penable = 1'b1;
		#(period / 4);
		data = apbRsp.prdata;
		checkValue("pslverr on read", {15'b0, apbRsp.pslverr}, 16'h0);
		@(negedge clk);
		apbReq = '0;
	endtask

	task automatic loadProgram();
		logic [15:0] word;
		logic slvErr;
		foreach (prog[i]) begin
			apbWrite(addrOf(regionInstr, 7'(i)), prog[i], slvErr);
			checkValue("pslverr on load", {15'b0, slvErr}, 16'h0);
		end
		foreach (prog[i]) begin
			apbRead(addrOf(regionInstr, 7'(i)), word);
			checkValue("instruction readback", word, prog[i]);
		end
	endtask

	// Poll status until the halt clears run
	task automatic waitHalt(output logic [6:0] pcAtHalt);
		logic [15:0] status;
		do apbRead(ctrlAddr, status); while (status[15]);
		pcAtHalt = status[6:0];
	endtask

	initial begin
		#((2 * resetCycles + maxTransfers * cycleBudget) * period);
		$display("Watchdog expired before the tests finished");
		$display("tests failed");
		$finish;
	end

	initial begin
		apbReq = '0;
		void'($urandom(49));
		applyReset();

		apbRead(ctrlAddr, rdata);
		checkValue("status after reset", rdata, 16'h0000);

		// Arithmetic program stores its results at data words 16..23
		a = {8'h00, 8'($urandom())};
		b = {8'h00, 8'($urandom())};
		expected = '{a + b, a - b, a & b, a | b, a ^ b, a << 1, a >> 1, b};
		prog.push_back(immInstr(opLdi, 2, b[7:0]));
		for (int k = 0; k < 8; k++) begin
			prog.push_back(immInstr(opLdi, 3, a[7:0]));
			prog.push_back(regInstr(aluOps[k], 3, 2));
			prog.push_back(immInstr(opLdi, 4, 8'(16 + k)));
			prog.push_back(regInstr(opSt, 4, 3));
		end
		// Copy word 100 to word 101 through a register
		prog.push_back(immInstr(opLdi, 9, 100));
		prog.push_back(regInstr(opLd, 10, 9));
		prog.push_back(immInstr(opLdi, 11, 101));
		prog.push_back(regInstr(opSt, 11, 10));
		prog.push_back(regInstr(opHalt, 0, 0));
		loadProgram();
		apbWrite(addrOf(regionData, 100), 16'h1234, err);
		checkValue("pslverr on stopped write", {15'b0, err}, 16'h0);
		apbRead(addrOf(regionData, 100), rdata);
		checkValue("data readback", rdata, 16'h1234);

		apbWrite(ctrlAddr, 16'h0001, err);
		apbWrite(addrOf(regionData, 100), 16'hdead, err);
		checkValue("pslverr while running", {15'b0, err}, 16'h0001);
		waitHalt(haltPc);
		checkValue("arithmetic halt pc", {9'b0, haltPc}, 16'(prog.size() - 1));
		for (int k = 0; k < 8; k++) begin
			apbRead(addrOf(regionData, 7'(16 + k)), rdata);
			checkValue($sformatf("%s result", aluOps[k].name()), rdata, expected[k]);
		end
		apbRead(addrOf(regionData, 100), rdata);
		checkValue("word written while running", rdata, 16'h1234);
		apbRead(addrOf(regionData, 101), rdata);
		checkValue("load/store copy", rdata, 16'h1234);

		// PC still sits on the old halt, so start over from address 0
		applyReset();

		// Branch program leaves markers at data words 32..37
		prog = {immInstr(opLdi, 7, 8'haa), immInstr(opLdi, 1, 0), regInstr(opAdd, 1, 1),
			immInstr(opJz, 0, 6), immInstr(opLdi, 6, 32), regInstr(opSt, 6, 7),
			immInstr(opJc, 0, 9), immInstr(opLdi, 6, 33), regInstr(opSt, 6, 7),
			immInstr(opLdi, 2, 1), regInstr(opSub, 1, 2), immInstr(opJc, 0, 14),
			immInstr(opLdi, 6, 34), regInstr(opSt, 6, 7), immInstr(opJz, 0, 17),
			immInstr(opLdi, 6, 35), regInstr(opSt, 6, 7), immInstr(opJmp, 0, 20),
			immInstr(opLdi, 6, 36), regInstr(opSt, 6, 7), immInstr(opLdi, 3, 24),
			regInstr(opJr, 0, 3), immInstr(opLdi, 6, 37), regInstr(opSt, 6, 7),
			regInstr(opHalt, 0, 0)};
		loadProgram();
		for (int k = 32; k < 38; k++) begin
			apbWrite(addrOf(regionData, 7'(k)), 16'h0000, err);
		end
		apbWrite(ctrlAddr, 16'h0001, err);
		waitHalt(haltPc);
		checkValue("branch halt pc", {9'b0, haltPc}, 16'd24);
		markers = '{16'h0000, 16'h00aa, 16'h0000, 16'h00aa, 16'h0000, 16'h0000};
		for (int k = 0; k < 6; k++) begin
			apbRead(addrOf(regionData, 7'(32 + k)), rdata);
			checkValue($sformatf("branch marker %0d", 32 + k), rdata, markers[k]);
		end

		$display("Run finished with %0d errors", errorCount);
		if (errorCount == 0) begin
			$display("all tests passed");
		end
		else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
	input wire logic clk,
	input wire logic rst,
	input wire logic we,
	input wire logic [3:0] dstIdx,
	input wire logic [3:0] srcIdx,
	input wire logic [cpuPkg::dataWidth-1:0] writeData,
	output logic [cpuPkg::dataWidth-1:0] dstData,
	output logic [cpuPkg::dataWidth-1:0] srcData
);
	import cpuPkg::*;

	logic [dataWidth-1:0] regs [16];

	// Single write port, dst register only
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end
		else if (we) begin
			regs[dstIdx] <= writeData;
		end
	end

	// Both read ports are asynchronous
	assign dstData = regs[dstIdx];
	assign srcData = regs[srcIdx];

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the processor testbench with Verilator
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f vlog.f --top-module processorTb -o processorSim \
	&& ./obj_dir/processorSim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "tests failed" sim.log && exit 1
grep -q "all tests passed" sim.log || exit 1
exit 0

// File: vlog.f
cpuPkg.sv
regFile.sv
alu.sv
decoder.sv
memorySystem.sv
processor.sv
processorTb.sv
